// ==== mem_bridge.f ====
verilog/mem_bridge_pkg.sv
verilog/byte_fifo.sv
verilog/cmd_parser.sv
verilog/mem_transfer_engine.sv
verilog/mem_bridge.sv
testbench/mem_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the mem_bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -j 0 \
    --top-module mem_bridge_tb \
    --Mdir "${BUILD_DIR}" \
    -f mem_bridge.f

# Exit status of the simulator is not used, the log decides
"./${BUILD_DIR}/Vmem_bridge_tb" 2>&1 | tee "${LOG_FILE}"

if grep -q "^Simulation PASSED$" "${LOG_FILE}"; then
    echo "Test run passed"
    exit 0
else
    echo "Test run failed, see ${LOG_FILE}"
    exit 1
fi

// ==== testbench/mem_bridge_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_bridge_tb;

    import mem_bridge_pkg::*;

    localparam int FIFO_DEPTH = 16;
    localparam int MEM_DEPTH  = 16384;
    localparam int ADDR_W     = $clog2(MEM_DEPTH);

    // Bytes moved by each test in order including headers
    localparam int TOTAL_BYTES     = 18 + 34 + 42 + 98 + 26 + 26;
    localparam int WATCHDOG_CYCLES = 200 * TOTAL_BYTES;

    logic  i_clk;
    logic  i_rst_n;
    logic  i_data_valid;
    byte_t i_data;
    logic  o_input_full;
    logic  i_data_read;
    byte_t o_data;
    logic  o_output_empty;

    byte_t       model_mem [MEM_DEPTH];
    logic [15:0] lfsr_state;

    mem_bridge #(.FIFO_DEPTH(FIFO_DEPTH), .MEM_DEPTH(MEM_DEPTH)) mem_bridge_i
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_data_valid   (i_data_valid),
        .i_data         (i_data),
        .o_input_full   (o_input_full),
        .i_data_read    (i_data_read),
        .o_data         (o_data),
        .o_output_empty (o_output_empty)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("Error: watchdog expired after %0d cycles, the DUT stopped responding",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $fatal(1, "Watchdog timeout");
    end

    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ 16'hB400;
        else
            return state >> 1;
    endfunction

    task automatic random_byte(output byte_t value);
        value = '0;
        for (int i = 0; i < 8; i++)
        begin
            value      = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Memory wraps modulo its depth
    function automatic logic [ADDR_W-1:0] model_index(input logic [FIELD_W-1:0] addr);
        return ADDR_W'(addr % 32'(MEM_DEPTH));
    endfunction

    // Zero size moves a single byte
    function automatic int byte_count(input logic [FIELD_W-1:0] size);
        return (size == '0) ? 1 : int'(size);
    endfunction

    function automatic cmd_t make_cmd(input byte_t op, input logic [FIELD_W-1:0] addr,
                                      input logic [FIELD_W-1:0] size);
        cmd_t cmd;
        cmd.op   = cmd_op_t'(op);
        cmd.addr = addr;
        cmd.size = size;
        return cmd;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic check_byte(input string what, input byte_t expected, input byte_t actual);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s, expected 0x%02h, got 0x%02h",
                     $time, what, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Byte mismatch");
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s, expected %b, got %b", $time, what, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Flag mismatch");
        end
    endtask

    task automatic send_byte(input byte_t value);
        while (o_input_full)
            next_cycle();
        i_data_valid = 1'b1;
        i_data       = value;
        next_cycle();
        i_data_valid = 1'b0;
    endtask

    task automatic read_byte(output byte_t value);
        while (o_output_empty)
            next_cycle();
        value       = o_data;
        i_data_read = 1'b1;
        next_cycle();
        i_data_read = 1'b0;
    endtask

    // Opcode, then address and size LSB first
    task automatic send_cmd(input cmd_t cmd);
        send_byte(byte_t'(cmd.op));
        for (int i = 0; i < FIELD_W / 8; i++)
            send_byte(cmd.addr[8*i +: 8]);
        for (int i = 0; i < FIELD_W / 8; i++)
            send_byte(cmd.size[8*i +: 8]);
    endtask

    task automatic write_block(input logic [FIELD_W-1:0] addr, input logic [FIELD_W-1:0] size);
        byte_t value;
        send_cmd(make_cmd(cmd_op_write, addr, size));
        for (int i = 0; i < byte_count(size); i++)
        begin
            random_byte(value);
            model_mem[model_index(addr + FIELD_W'(i))] = value;
            send_byte(value);
        end
    endtask

    task automatic drain_and_check(input logic [FIELD_W-1:0] addr,
                                   input logic [FIELD_W-1:0] size);
        byte_t value;
        for (int i = 0; i < byte_count(size); i++)
        begin
            read_byte(value);
            check_byte($sformatf("read byte %0d from address 0x%08h", i, addr),
                       model_mem[model_index(addr + FIELD_W'(i))], value);
        end
    endtask

    task automatic read_block(input logic [FIELD_W-1:0] addr, input logic [FIELD_W-1:0] size);
        send_cmd(make_cmd(cmd_op_read, addr, size));
        drain_and_check(addr, size);
    endtask

    task automatic expect_no_output(input int cycles);
        repeat (cycles)
        begin
            check_flag("o_output_empty with no read pending", 1'b1, o_output_empty);
            next_cycle();
        end
    endtask

    task automatic reset_and_idle_parse();
        check_flag("o_output_empty after reset", 1'b1, o_output_empty);
        check_flag("o_input_full after reset", 1'b0, o_input_full);
        // One header with an unknown opcode and most of a second one
        for (int i = 0; i < 16; i++)
            send_byte(8'hA0 + 8'(i));
        expect_no_output(20);
        check_flag("o_input_full after the parser consumed the stream", 1'b0, o_input_full);
        // Complete the second header so later commands stay aligned
        send_byte(8'hB0);
        send_byte(8'hB1);
        expect_no_output(20);
    endtask

    task automatic write_then_read();
        write_block(32'd100, 32'd8);
        read_block(32'd100, 32'd8);
    endtask

    task automatic zero_size_transfers();
        write_block(32'd300, 32'd2);
        write_block(32'd300, 32'd0);
        // Second byte must still hold the earlier data
        read_block(32'd300, 32'd2);
        read_block(32'd300, 32'd0);
        expect_no_output(20);
    endtask

    task automatic long_read_with_stall();
        write_block(32'd1000, 32'd40);
        send_cmd(make_cmd(cmd_op_read, 32'd1000, 32'd40));
        while (o_output_empty)
            next_cycle();
        // Output FIFO fills up and the engine stalls
        repeat (4 * FIFO_DEPTH)
            next_cycle();
        drain_and_check(32'd1000, 32'd40);
        expect_no_output(10);
    endtask

    task automatic unknown_opcode_ignored();
        send_cmd(make_cmd(8'd7, 32'd100, 32'd8));
        expect_no_output(30);
        read_block(32'd100, 32'd8);
    endtask

    task automatic address_wraps();
        write_block(FIELD_W'(MEM_DEPTH + 4), 32'd4);
        read_block(32'd4, 32'd4);
    endtask

    initial
    begin
        i_rst_n      = 1'b0;
        i_data_valid = 1'b0;
        i_data       = '0;
        i_data_read  = 1'b0;
        lfsr_state   = 16'd6;
        repeat (3) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        next_cycle();

        reset_and_idle_parse();
        write_then_read();
        zero_size_transfers();
        long_read_with_stall();
        unknown_opcode_ignored();
        address_wraps();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/mem_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_bridge
#(
    parameter int FIFO_DEPTH = 16,
    parameter int MEM_DEPTH  = 16384
)
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    input  logic                  i_data_valid,
    input  mem_bridge_pkg::byte_t i_data,
    output logic                  o_input_full,

    input  logic                  i_data_read,
    output mem_bridge_pkg::byte_t o_data,
    output logic                  o_output_empty
);

    import mem_bridge_pkg::*;

    // Input FIFO to parser
    logic  w_in_empty;
    logic  w_in_rd;
    byte_t w_in_data;

    // Parser to engine
    logic  w_cmd_valid;
    cmd_t  w_cmd;
    logic  w_wr_valid;
    byte_t w_wr_byte;
    logic  w_busy;

    // Engine to output FIFO
    logic  w_out_full;
    logic  w_push;
    byte_t w_push_data;

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) in_fifo_i
    (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr      (i_data_valid),
        .i_wr_data (i_data),
        .i_rd      (w_in_rd),
        .o_data    (w_in_data),
        .o_full    (o_input_full),
        .o_empty   (w_in_empty)
    );

    cmd_parser cmd_parser_i
    (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_fifo_empty (w_in_empty),
        .i_fifo_data  (w_in_data),
        .o_fifo_rd    (w_in_rd),
        .i_busy       (w_busy),
        .o_cmd_valid  (w_cmd_valid),
        .o_cmd        (w_cmd),
        .o_wr_valid   (w_wr_valid),
        .o_wr_byte    (w_wr_byte)
    );

    mem_transfer_engine #(.MEM_DEPTH(MEM_DEPTH)) engine_i
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd_valid (w_cmd_valid),
        .i_cmd       (w_cmd),
        .i_wr_valid  (w_wr_valid),
        .i_wr_byte   (w_wr_byte),
        .i_out_full  (w_out_full),
        .o_busy      (w_busy),
        .o_push      (w_push),
        .o_push_data (w_push_data)
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) out_fifo_i
    (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr      (w_push),
        .i_wr_data (w_push_data),
        .i_rd      (i_data_read),
        .o_data    (o_data),
        .o_full    (w_out_full),
        .o_empty   (o_output_empty)
    );

endmodule

`default_nettype wire

// ==== verilog/mem_transfer_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_transfer_engine
#(
    parameter int MEM_DEPTH = 16384
)
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    input  logic                  i_cmd_valid,
    input  mem_bridge_pkg::cmd_t  i_cmd,

    input  logic                  i_wr_valid,
    input  mem_bridge_pkg::byte_t i_wr_byte,

    input  logic                  i_out_full,

    output logic                  o_busy,
    output logic                  o_push,
    output mem_bridge_pkg::byte_t o_push_data
);

    import mem_bridge_pkg::*;

    localparam int ADDR_W = $clog2(MEM_DEPTH);

    byte_t              r_mem [MEM_DEPTH];

    logic [ADDR_W-1:0]  r_cur_addr;
    logic [ADDR_W-1:0]  r_end_addr;

    logic [ADDR_W-1:0]  w_start_addr;
    logic [FIELD_W-1:0] w_end_addr_full;
    logic               w_is_read;
    logic               w_is_write;

    // Only the low address bits select a byte, higher addresses wrap
    assign w_start_addr = i_cmd.addr[ADDR_W-1:0];

    // A zero size still moves one byte
    assign w_end_addr_full = (i_cmd.size != '0) ? (i_cmd.addr + (i_cmd.size - 1'b1))
                                                : i_cmd.addr;

    assign w_is_read  = i_cmd_valid && (i_cmd.op == cmd_op_read);
    assign w_is_write = i_cmd_valid && (i_cmd.op == cmd_op_write);

    // Push while reading and the output FIFO has room
    assign o_push      = o_busy && !i_out_full;
    assign o_push_data = r_mem[r_cur_addr];

    always_ff @(posedge i_clk)
    begin
        if (i_wr_valid)
            r_mem[r_cur_addr] <= i_wr_byte;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_busy     <= 1'b0;
            r_cur_addr <= '0;
            r_end_addr <= '0;
        end
        else
        begin
            if (w_is_read)
            begin
                r_cur_addr <= w_start_addr;
                r_end_addr <= w_end_addr_full[ADDR_W-1:0];
                o_busy     <= 1'b1;
            end
            else if (w_is_write)
                r_cur_addr <= w_start_addr;
            else if (i_wr_valid)
                r_cur_addr <= r_cur_addr + 1'b1;
            else if (o_push)
            begin
                // Last byte of the read leaves the engine idle
                if (r_cur_addr == r_end_addr)
                    o_busy <= 1'b0;
                else
                    r_cur_addr <= r_cur_addr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cmd_parser.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmd_parser
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    input  logic                  i_fifo_empty,
    input  mem_bridge_pkg::byte_t i_fifo_data,
    output logic                  o_fifo_rd,

    input  logic                  i_busy,

    output logic                  o_cmd_valid,
    output mem_bridge_pkg::cmd_t  o_cmd,

    output logic                  o_wr_valid,
    output mem_bridge_pkg::byte_t o_wr_byte
);

    import mem_bridge_pkg::*;

    localparam int CNT_W = $clog2(HEADER_BYTES);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(HEADER_BYTES - 1);

    typedef enum logic
    {
        st_header,
        st_payload
    } parser_state_t;

    parser_state_t      r_state;
    logic [CNT_W-1:0]   r_byte_cnt;
    logic [FIELD_W-1:0] r_remaining;

    logic               w_hdr_pop_ok;
    logic               w_pop;
    logic [FIELD_W-1:0] w_next_size;

    // Header bytes wait until the engine is idle and the last strobe is gone
    assign w_hdr_pop_ok = (r_state == st_header) && !i_busy && !o_cmd_valid;
    assign w_pop        = !i_fifo_empty && (w_hdr_pop_ok || (r_state == st_payload));
    assign o_fifo_rd    = w_pop;

    // Size as it will be once the byte at the head is shifted in
    assign w_next_size = {i_fifo_data, o_cmd.size[FIELD_W-1:8]};

    always_ff @(posedge i_clk)
    begin
        if (w_pop && (r_state == st_header))
        begin
            if (r_byte_cnt == '0)
                o_cmd.op <= cmd_op_t'(i_fifo_data);
            else if (r_byte_cnt <= CNT_W'(FIELD_W / 8))
                o_cmd.addr <= {i_fifo_data, o_cmd.addr[FIELD_W-1:8]};
            else
                o_cmd.size <= w_next_size;
        end

        if (w_pop && (r_state == st_payload))
            o_wr_byte <= i_fifo_data;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            r_state     <= st_header;
            r_byte_cnt  <= '0;
            r_remaining <= '0;
            o_cmd_valid <= 1'b0;
            o_wr_valid  <= 1'b0;
        end
        else
        begin
            o_cmd_valid <= 1'b0;
            o_wr_valid  <= 1'b0;

            if (w_pop && (r_state == st_header))
            begin
                if (r_byte_cnt == LAST_BYTE)
                begin
                    r_byte_cnt <= '0;

                    // Unknown opcodes are swallowed without a strobe
                    if (o_cmd.op == cmd_op_write)
                    begin
                        o_cmd_valid <= 1'b1;
                        r_state     <= st_payload;
                        r_remaining <= (w_next_size == '0) ? FIELD_W'(1) : w_next_size;
                    end
                    else if (o_cmd.op == cmd_op_read)
                        o_cmd_valid <= 1'b1;
                end
                else
                    r_byte_cnt <= r_byte_cnt + 1'b1;
            end
            else if (w_pop && (r_state == st_payload))
            begin
                o_wr_valid  <= 1'b1;
                r_remaining <= r_remaining - 1'b1;
                if (r_remaining == FIELD_W'(1))
                    r_state <= st_header;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/byte_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module byte_fifo
#(
    parameter int FIFO_DEPTH = 16
)
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    input  logic                  i_wr,
    input  mem_bridge_pkg::byte_t i_wr_data,

    input  logic                  i_rd,
    output mem_bridge_pkg::byte_t o_data,

    output logic                  o_full,
    output logic                  o_empty
);

    import mem_bridge_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_PTR   = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(FIFO_DEPTH);

    byte_t            r_buf [FIFO_DEPTH];
    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    logic [CNT_W-1:0] r_count;

    logic w_do_wr;
    logic w_do_rd;

    // Writes to a full FIFO and reads from an empty one are ignored
    assign w_do_wr = i_wr && !o_full;
    assign w_do_rd = i_rd && !o_empty;

    assign o_full  = (r_count == FULL_COUNT);
    assign o_empty = (r_count == '0);

    // Head of the queue, first word fall through
    assign o_data = r_buf[r_rd_ptr];

    always_ff @(posedge i_clk)
    begin
        if (w_do_wr)
            r_buf[r_wr_ptr] <= i_wr_data;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end
        else
        begin
            if (w_do_wr)
                r_wr_ptr <= (r_wr_ptr == LAST_PTR) ? '0 : r_wr_ptr + 1'b1;

            if (w_do_rd)
                r_rd_ptr <= (r_rd_ptr == LAST_PTR) ? '0 : r_rd_ptr + 1'b1;

            if (w_do_wr && !w_do_rd)
                r_count <= r_count + 1'b1;
            else if (w_do_rd && !w_do_wr)
                r_count <= r_count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_bridge_pkg.sv ====
`default_nettype none

package mem_bridge_pkg;

    // One byte of the host stream or of the bridge memory
    typedef logic [7:0] byte_t;

    // Width of the address and size fields in a command header
    localparam int FIELD_W = 32;

    // Opcode byte, then address and size, each LSB first
    localparam int HEADER_BYTES = 1 + (FIELD_W / 8) * 2;

    // Memory commands understood by the bridge
    typedef enum logic [7:0]
    {
        cmd_op_read  = 8'd1,
        cmd_op_write = 8'd2
    } cmd_op_t;

    // Decoded command header, 72 bits
    typedef struct packed
    {
        cmd_op_t              op;
        logic [FIELD_W-1:0]   addr;
        logic [FIELD_W-1:0]   size;
    } cmd_t;

endpackage

`default_nettype wire
